/* branch_folder.sv */
`default_nettype none

module branch_folder
    import ctrl_params_pkg::*, ctrl_types_pkg::*;
(
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire alu_write_t          alu_write,
    input  wire issue_t              issue,
    output logic                     jump,
    output logic      [PC_WIDTH-1:0] destination,
    output logic                     cancel
);

    logic [WADDR_WIDTH-1:0]  bt_offset;
    logic [THREAD_WIDTH-1:0] bt_index;
    logic                    bt_hit;
    logic                    bt_wren;

    branch_entry_t           bt_q [THREAD_COUNT];
    branch_entry_t           entry;

    logic [DATA_WIDTH-1:0]   r_prev;
    logic                    origin_hit;
    logic                    cond_hold;

    // branch-table window decode.
    assign bt_offset = alu_write.addr - WADDR_WIDTH'(BT_BASE);
    assign bt_hit    = bt_offset < WADDR_WIDTH'(THREAD_COUNT);
    assign bt_index  = bt_offset[THREAD_WIDTH-1:0];
    assign bt_wren   = alu_write.wren & bt_hit;

    // one entry per thread, cleared to COND_NEVER.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                bt_q[t] <= '0;
            end
        end else if (bt_wren) begin
            bt_q[bt_index] <= alu_write.data.branch;
        end
    end

    // entry of the thread issuing now.
    assign entry = bt_q[issue.thread];

    // the write data bus carries the previous result.
    assign r_prev = alu_write.data;

    assign origin_hit = issue.pc == entry.origin;

    always_comb begin
        unique case (entry.cond)
            COND_NEVER:   cond_hold = 1'b0;
            COND_ALWAYS:  cond_hold = 1'b1;
            COND_ZERO:    cond_hold = r_prev == '0;
            COND_NONZERO: cond_hold = r_prev != '0;
        endcase
    end

    // folded branch, taken in the issue cycle of its origin.
    assign jump        = origin_hit & cond_hold;
    assign destination = entry.destination;

    // kill the instruction issued with the branch.
    assign cancel = jump & entry.cancel_en;

    a_cancel_needs_jump : assert property (
        @(posedge clock) disable iff (reset)
            cancel |-> jump
    ) else $error("branch_folder: cancel raised without a taken branch");

endmodule

`default_nettype wire

/* control_path.sv */
`default_nettype none

module control_path
    import ctrl_params_pkg::*, ctrl_types_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire alu_write_t alu_write,
    input  wire logic       io_ready,
    output fetch_t          fetch,
    output logic            cancel
);

    issue_t                 issue;
    issue_t                 issue_tag;
    logic                   jump;
    logic [PC_WIDTH-1:0]    destination;
    logic                   ready_eff;
    logic [INSTR_WIDTH-1:0] instr_ram;
    logic [INSTR_WIDTH-1:0] instr_tap;

    instr_mem u_instr_mem (
        .clock     (clock),
        .alu_write (alu_write),
        .read_pc   (issue.pc),
        .instr     (instr_ram)
    );

    // extra stages after the RAM read, kept for timing.
    delay_line #(
        .DEPTH (I_TAP_DEPTH),
        .WIDTH (INSTR_WIDTH)
    ) u_instr_tap (
        .clock (clock),
        .reset (reset),
        .din   (instr_ram),
        .dout  (instr_tap)
    );

    // tag follows the RAM read stage plus the tap stages.
    delay_line #(
        .DEPTH (1 + I_TAP_DEPTH),
        .WIDTH ($bits(issue_t))
    ) u_tag_tap (
        .clock (clock),
        .reset (reset),
        .din   (issue),
        .dout  (issue_tag)
    );

    branch_folder u_branch_folder (
        .clock       (clock),
        .reset       (reset),
        .alu_write   (alu_write),
        .issue       (issue),
        .jump        (jump),
        .destination (destination),
        .cancel      (cancel)
    );

    // a cancelled instruction counts as done, no re-issue.
    assign ready_eff = io_ready | cancel;

    thread_pc u_thread_pc (
        .clock       (clock),
        .reset       (reset),
        .jump        (jump),
        .destination (destination),
        .ready       (ready_eff),
        .issue       (issue)
    );

    assign fetch.instr  = instr_tap;
    assign fetch.thread = issue_tag.thread;
    assign fetch.pc     = issue_tag.pc;

endmodule

`default_nettype wire

/* control_path_tb.sv */
`default_nettype none

module control_path_tb
    import ctrl_params_pkg::*, ctrl_types_pkg::*;
();

    localparam int PERIOD             = 4;
    localparam int RESET_CYCLES       = 3;
    localparam int FETCH_LATENCY      = 1 + I_TAP_DEPTH;
    localparam int LOAD_RUN_CYCLES    = 64;
    localparam int RESET_TEST_CYCLES  = FETCH_LATENCY + THREAD_COUNT;
    localparam int LOAD_TEST_CYCLES   = I_DEPTH + LOAD_RUN_CYCLES;
    localparam int HOLD_TEST_CYCLES   = 36;
    localparam int BRANCH_TEST_CYCLES = 2 * (THREAD_COUNT + 4 * THREAD_COUNT);
    localparam int CANCEL_TEST_CYCLES = 2 + 2 * THREAD_COUNT;
    localparam int WINDOW_TEST_CYCLES = 2 + THREAD_COUNT + 10 * THREAD_COUNT;
    localparam int MARGIN_CYCLES      = 50;
    localparam int WATCHDOG_CYCLES    = RESET_CYCLES + RESET_TEST_CYCLES + LOAD_TEST_CYCLES
                                      + HOLD_TEST_CYCLES + BRANCH_TEST_CYCLES
                                      + CANCEL_TEST_CYCLES + WINDOW_TEST_CYCLES
                                      + MARGIN_CYCLES;

    // expected fetch, instr only compared once the word is known.
    typedef struct packed {
        logic   instr_known;
        fetch_t f;
    } expect_t;

    logic       clock = 1'b0;
    logic       reset;
    alu_write_t alu_write;
    logic       io_ready;
    fetch_t     fetch;
    logic       cancel;

    integer seed;
    int     errors;
    int     checks;
    int     taken_count;
    int     cancel_count;
    fetch_t seen_fetch;
    logic   seen_cancel;
    logic   seen_jump;

    // reference model of the barrel.
    logic [INSTR_WIDTH-1:0]  model_mem [I_DEPTH];
    logic                    model_known [I_DEPTH];
    branch_entry_t           model_bt [THREAD_COUNT];
    logic [PC_WIDTH-1:0]     model_pc [THREAD_COUNT];
    logic [THREAD_WIDTH-1:0] model_thread;
    expect_t                 expect_q [$];

    control_path u_control_path (
        .clock     (clock),
        .reset     (reset),
        .alu_write (alu_write),
        .io_ready  (io_ready),
        .fetch     (fetch),
        .cancel    (cancel)
    );

    always #(PERIOD / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR: %s got %h expected %h at time %0t", name, got, exp, $time);
        end
    endtask

    task automatic init_model();
        expect_t none;
        none = '0;
        for (int i = 0; i < I_DEPTH; i++) begin
            model_known[PC_WIDTH'(i)] = 1'b0;
        end
        for (int t = 0; t < THREAD_COUNT; t++) begin
            model_bt[THREAD_WIDTH'(t)] = '0;
            model_pc[THREAD_WIDTH'(t)] = PC_WIDTH'(t * PC_START_STRIDE);
        end
        model_thread = '0;
        // the tap registers come out of reset as zero words.
        repeat (FETCH_LATENCY) expect_q.push_back(none);
    endtask

    // one clock: drive, sample at the falling edge, step the model.
    task automatic drive_cycle(input alu_write_t w, input logic rdy);
        logic [THREAD_WIDTH-1:0] t;
        branch_entry_t           e;
        logic                    cond_ok;
        logic                    jump_exp;
        logic                    cancel_exp;
        expect_t                 head;
        expect_t                 cur;
        int                      addr_i;
        alu_write = w;
        io_ready  = rdy;
        @(negedge clock);
        seen_fetch  = fetch;
        seen_cancel = cancel;
        seen_jump   = u_control_path.jump;
        t = model_thread;
        e = model_bt[t];
        case (e.cond)
            COND_ALWAYS:  cond_ok = 1'b1;
            COND_ZERO:    cond_ok = (w.data.instr == '0);
            COND_NONZERO: cond_ok = (w.data.instr != '0);
            default:      cond_ok = 1'b0;
        endcase
        jump_exp   = cond_ok && (model_pc[t] == e.origin);
        cancel_exp = jump_exp && e.cancel_en;
        check_value("cancel", 32'(seen_cancel), 32'(cancel_exp));
        head = expect_q.pop_front();
        check_value("fetch.thread", 32'(seen_fetch.thread), 32'(head.f.thread));
        check_value("fetch.pc", 32'(seen_fetch.pc), 32'(head.f.pc));
        if (head.instr_known) begin
            check_value("fetch.instr", seen_fetch.instr, head.f.instr);
        end
        // read happens before this cycle's write lands.
        cur.instr_known = model_known[model_pc[t]];
        cur.f.instr     = model_mem[model_pc[t]];
        cur.f.thread    = t;
        cur.f.pc        = model_pc[t];
        expect_q.push_back(cur);
        if (seen_jump) begin
            taken_count++;
        end
        if (seen_cancel) begin
            cancel_count++;
        end
        if (jump_exp) begin
            model_pc[t] = e.destination;
        end else if (rdy || cancel_exp) begin
            model_pc[t] = model_pc[t] + 1'b1;
        end
        addr_i = int'(w.addr);
        if (w.wren && addr_i >= I_BASE && addr_i < I_BASE + I_DEPTH) begin
            model_mem[PC_WIDTH'(addr_i - I_BASE)]   = w.data.instr;
            model_known[PC_WIDTH'(addr_i - I_BASE)] = 1'b1;
        end
        if (w.wren && addr_i >= BT_BASE && addr_i < BT_BASE + THREAD_COUNT) begin
            model_bt[THREAD_WIDTH'(addr_i - BT_BASE)] = w.data.branch;
        end
        model_thread = model_thread + 1'b1;
        @(posedge clock);
        #1;
    endtask

    task automatic run_idle(input int cycles, input logic rdy);
        for (int i = 0; i < cycles; i++) begin
            drive_cycle('0, rdy);
        end
    endtask

    // writes hold the barrel so origins stay where they were set.
    task automatic write_word(input int addr, input logic [DATA_WIDTH-1:0] data);
        alu_write_t w;
        w = '0;
        w.wren       = 1'b1;
        w.addr       = WADDR_WIDTH'(addr);
        w.data.instr = data;
        drive_cycle(w, 1'b0);
    endtask

    task automatic write_entry(input int t, input cond_e cond, input logic cancel_en,
                               input logic [PC_WIDTH-1:0] origin,
                               input logic [PC_WIDTH-1:0] dest);
        branch_entry_t e;
        e = '0;
        e.cancel_en   = cancel_en;
        e.cond        = cond;
        e.destination = dest;
        e.origin      = origin;
        write_word(BT_BASE + t, e);
    endtask

    task automatic test_reset();
        check_value("cancel", 32'(cancel), 32'h0);
        for (int i = 0; i < RESET_TEST_CYCLES; i++) begin
            drive_cycle('0, 1'b1);
            if (i >= FETCH_LATENCY) begin
                check_value("fetch.thread", 32'(seen_fetch.thread), 32'(i - FETCH_LATENCY));
                check_value("fetch.pc", 32'(seen_fetch.pc),
                            32'((i - FETCH_LATENCY) * PC_START_STRIDE));
            end
        end
    endtask

    task automatic test_load();
        logic [PC_WIDTH-1:0] issued_pc [LOAD_RUN_CYCLES];
        logic [PC_WIDTH-1:0] next_pc;
        for (int a = 0; a < I_DEPTH; a++) begin
            write_word(I_BASE + a, $random(seed));
        end
        for (int i = 0; i < LOAD_RUN_CYCLES; i++) begin
            issued_pc[i] = model_pc[model_thread];
            drive_cycle('0, 1'b1);
            // one turn after issue i-7 of the same thread.
            if (i >= FETCH_LATENCY + THREAD_COUNT) begin
                next_pc = issued_pc[i - FETCH_LATENCY - THREAD_COUNT] + 1'b1;
                check_value("fetch.pc", 32'(seen_fetch.pc), 32'(next_pc));
            end
        end
    endtask

    task automatic test_hold();
        logic [PC_WIDTH-1:0] issued_pc [HOLD_TEST_CYCLES];
        logic                rdy_hist [HOLD_TEST_CYCLES];
        for (int i = 0; i < HOLD_TEST_CYCLES; i++) begin
            issued_pc[i] = model_pc[model_thread];
            rdy_hist[i]  = (i % 7) != 3;
            drive_cycle('0, rdy_hist[i]);
            // held at i-7, the same thread's next turn shows at i.
            if (i >= 7 && !rdy_hist[i - 7]) begin
                check_value("fetch.pc", 32'(seen_fetch.pc), 32'(issued_pc[i - 7]));
                check_value("fetch.instr", seen_fetch.instr, model_mem[issued_pc[i - 7]]);
            end
        end
    endtask

    task automatic test_branch();
        cond_e      conds [THREAD_COUNT];
        alu_write_t w;
        int         expected;
        conds = '{COND_ALWAYS, COND_ZERO, COND_NONZERO, COND_ZERO};
        for (int phase = 0; phase < 2; phase++) begin
            taken_count = 0;
            for (int t = 0; t < THREAD_COUNT; t++) begin
                write_entry(t, conds[THREAD_WIDTH'(t)], 1'b0,
                            model_pc[THREAD_WIDTH'(t)] + 8'd2,
                            model_pc[THREAD_WIDTH'(t)] + 8'h22);
            end
            for (int i = 0; i < 4 * THREAD_COUNT; i++) begin
                w = '0;
                // zero result for the low threads first, for the high ones after.
                w.data.instr = (model_thread[1] == phase[0]) ? '0 : 32'h0000_5a5a;
                drive_cycle(w, 1'b1);
            end
            expected = (phase == 0) ? 3 : 2;
            assert (taken_count == expected) else begin
                errors++;
                $display("branch phase %0d took %0d branches instead of %0d",
                         phase, taken_count, expected);
            end
        end
    endtask

    task automatic test_cancel();
        cancel_count = 0;
        taken_count  = 0;
        write_entry(0, COND_ALWAYS, 1'b1, model_pc[2'd0], model_pc[2'd0] + 8'h40);
        write_entry(1, COND_ALWAYS, 1'b0, model_pc[2'd1], model_pc[2'd1] + 8'h40);
        run_idle(2 * THREAD_COUNT, 1'b0);
        assert (cancel_count == 1 && taken_count == 2) else begin
            errors++;
            $display("cancel test saw %0d cancels and %0d jumps, expected one and two",
                     cancel_count, taken_count);
        end
    endtask

    task automatic test_window();
        taken_count = 0;
        // thread 2 lands on the RAM word that BT_BASE + 2 would alias.
        write_entry(2, COND_ALWAYS, 1'b0, model_pc[2'd2] + 8'd2, PC_WIDTH'(BT_BASE + 2));
        run_idle(5 * THREAD_COUNT, 1'b1);
        write_entry(3, COND_ALWAYS, 1'b0, model_pc[2'd3] + 8'd2, model_pc[2'd3] + 8'h30);
        for (int a = 0; a < THREAD_COUNT; a++) begin
            write_word(I_BASE + a, $random(seed));
        end
        run_idle(5 * THREAD_COUNT, 1'b1);
        assert (taken_count == 2) else begin
            errors++;
            $display("window test took %0d branches instead of 2", taken_count);
        end
    endtask

    initial begin
        seed         = 32'h577e;
        reset        = 1'b1;
        alu_write    = '0;
        io_ready     = 1'b0;
        errors       = 0;
        checks       = 0;
        taken_count  = 0;
        cancel_count = 0;
        init_model();
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        test_reset();
        test_load();
        test_hold();
        test_branch();
        test_cancel();
        test_window();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* ctrl_params_pkg.sv */
`default_nettype none

package ctrl_params_pkg;

    // barrel of hardware threads, one issue per clock.
    localparam int THREAD_COUNT = 4;
    localparam int THREAD_WIDTH = 2;

    // program counter and word widths.
    localparam int PC_WIDTH    = 8;
    localparam int INSTR_WIDTH = 32;
    localparam int DATA_WIDTH  = 32;

    // ALU write address space.
    localparam int WADDR_WIDTH = 10;

    // instruction window in the ALU write space.
    localparam int I_BASE  = 0;
    localparam int I_DEPTH = 256;

    // one branch entry per thread, at BT_BASE + thread.
    localparam int BT_BASE = 256;

    // registers between the RAM output and the fetch port.
    localparam int I_TAP_DEPTH = 2;

    // thread t starts at t * PC_START_STRIDE.
    localparam int PC_START_STRIDE = 64;

endpackage

`default_nettype wire

/* ctrl_types_pkg.sv */
`default_nettype none

package ctrl_types_pkg;

    import ctrl_params_pkg::*;

    // branch condition, tested on the previous result.
    typedef enum logic [1:0] {
        COND_NEVER   = 2'd0,
        COND_ALWAYS  = 2'd1,
        COND_ZERO    = 2'd2,
        COND_NONZERO = 2'd3
    } cond_e;

    // one branch-table entry, fills a whole ALU word.
    typedef struct packed {
        logic [DATA_WIDTH-3-2*PC_WIDTH-1:0] unused;
        logic                               cancel_en;
        cond_e                              cond;
        logic [PC_WIDTH-1:0]                destination;
        logic [PC_WIDTH-1:0]                origin;
    } branch_entry_t;

    // ALU data word, read as an instruction or as a branch entry.
    typedef union packed {
        logic [INSTR_WIDTH-1:0] instr;
        branch_entry_t          branch;
    } alu_word_u;

    typedef struct packed {
        logic                   wren;
        logic [WADDR_WIDTH-1:0] addr;
        alu_word_u              data;
    } alu_write_t;

    typedef struct packed {
        logic [THREAD_WIDTH-1:0] thread;
        logic [PC_WIDTH-1:0]     pc;
    } issue_t;

    // instruction tagged with the issue it belongs to.
    typedef struct packed {
        logic [INSTR_WIDTH-1:0]  instr;
        logic [THREAD_WIDTH-1:0] thread;
        logic [PC_WIDTH-1:0]     pc;
    } fetch_t;

endpackage

`default_nettype wire

/* delay_line.sv */
`default_nettype none

module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic [WIDTH-1:0] din,
    output logic      [WIDTH-1:0] dout
);

    generate
        if (DEPTH == 0) begin : g_wire
            assign dout = din;
        end else begin : g_chain
            logic [WIDTH-1:0] stage [DEPTH];

            // shift one stage per clock, all stages in flight.
            always_ff @(posedge clock) begin
                if (reset) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= din;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            assign dout = stage[DEPTH-1];
        end
    endgenerate

endmodule

`default_nettype wire

/* instr_mem.sv */
`default_nettype none

module instr_mem
    import ctrl_params_pkg::*, ctrl_types_pkg::*;
(
    input  wire logic                   clock,
    input  wire alu_write_t             alu_write,
    input  wire logic [PC_WIDTH-1:0]    read_pc,
    output logic      [INSTR_WIDTH-1:0] instr
);

    logic [WADDR_WIDTH-1:0] wr_offset;
    logic [PC_WIDTH-1:0]    wr_index;
    logic                   in_window;
    logic                   ram_wren;

    logic [INSTR_WIDTH-1:0] ram [I_DEPTH];

    // offset wraps below the base, so one compare covers both ends.
    assign wr_offset = alu_write.addr - WADDR_WIDTH'(I_BASE);
    assign in_window = wr_offset < WADDR_WIDTH'(I_DEPTH);
    assign wr_index  = wr_offset[PC_WIDTH-1:0];
    assign ram_wren  = alu_write.wren & in_window;

    // simple dual port, read-first on a collision.
    always_ff @(posedge clock) begin
        if (ram_wren) begin
            ram[wr_index] <= alu_write.data.instr;
        end
        instr <= ram[read_pc];
    end

    // a write outside the window must leave the aliased word intact.
    property p_no_stray_write;
        @(posedge clock)
            (alu_write.wren && !in_window)
            |=> (ram[$past(wr_index)] === $past(ram[wr_index]));
    endproperty

    a_no_stray_write : assert property (p_no_stray_write)
        else $error("instr_mem: write outside the instruction window changed the RAM");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module control_path_tb \
    -f vlog.f

sim_status=0
./obj_dir/Vcontrol_path_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit "$sim_status"
fi

/* thread_pc.sv */
`default_nettype none

module thread_pc
    import ctrl_params_pkg::*, ctrl_types_pkg::*;
(
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                jump,
    input  wire logic [PC_WIDTH-1:0] destination,
    input  wire logic                ready,
    output issue_t                   issue
);

    logic [THREAD_WIDTH-1:0] thread_q;
    logic [THREAD_WIDTH-1:0] thread_next;
    logic [PC_WIDTH-1:0]     pc_q [THREAD_COUNT];
    logic [PC_WIDTH-1:0]     pc_cur;
    logic [PC_WIDTH-1:0]     pc_next;

    // strict round robin over the barrel.
    assign thread_next = (thread_q == THREAD_WIDTH'(THREAD_COUNT - 1))
                       ? '0
                       : thread_q + 1'b1;

    assign pc_cur = pc_q[thread_q];

    // jump wins over step, otherwise hold.
    always_comb begin
        if (jump) begin
            pc_next = destination;
        end else if (ready) begin
            pc_next = pc_cur + 1'b1;
        end else begin
            pc_next = pc_cur;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            thread_q <= '0;
            for (int t = 0; t < THREAD_COUNT; t++) begin
                pc_q[t] <= PC_WIDTH'(t * PC_START_STRIDE);
            end
        end else begin
            thread_q         <= thread_next;
            pc_q[thread_q]   <= pc_next;
        end
    end

    assign issue.thread = thread_q;
    assign issue.pc     = pc_cur;

    // the barrel never stalls, even under back-pressure.
    a_thread_rotates : assert property (
        @(posedge clock) disable iff (reset)
            1'b1 |=> (thread_q == THREAD_WIDTH'($past(thread_q) + 1'b1))
    ) else $error("thread_pc: thread index did not advance by one");

endmodule

`default_nettype wire

/* vlog.f */
ctrl_params_pkg.sv
ctrl_types_pkg.sv
delay_line.sv
instr_mem.sv
branch_folder.sv
thread_pc.sv
control_path.sv
control_path_tb.sv
